// File: list.f
common/fetch_pkg.sv
if_stage/if_stage.sv
id_stage/id_stage.sv
verilog/fetch_front.sv
dv/inst_mem_model.sv
dv/tb_fetch_front.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch_front
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf $(BUILD_DIR)

// File: dv/tb_fetch_front.sv
`timescale 1ns/1ns

module tb_fetch_front;
    import fetch_pkg::*;

    localparam logic [addr_w-1:0] reset_pc = 32'h1c00_0000;
    localparam int n_exp   = 24;
    localparam int n_stall = 3;

    logic              clk;
    logic              reset;
    logic              inst_sram_req;
    logic [addr_w-1:0] inst_sram_addr;
    logic              inst_sram_addr_ok;
    logic              inst_sram_data_ok;
    logic [inst_w-1:0] inst_sram_rdata;
    logic              out_valid;
    logic [addr_w-1:0] out_pc;
    logic [inst_w-1:0] out_inst;
    logic              out_allowin;

    // {pc, inst} in program order with a nop in every slot after a B
    logic [63:0] exp_tab [0:n_exp-1] = '{
        64'h1c00_0000_0280_0401, 64'h1c00_0004_0280_0802,
        64'h1c00_0008_5000_2800, 64'h1c00_000c_0280_0000,
        64'h1c00_0030_0280_3012, 64'h1c00_0034_0280_3413,
        64'h1c00_0038_53ff_dfff, 64'h1c00_003c_0280_0000,   // backward to 0x14
        64'h1c00_0014_0280_1405,
        64'h1c00_0018_5000_2800, 64'h1c00_001c_0280_0000,   // forward exit
        64'h1c00_0040_0280_4016,
        64'h1c00_0044_0280_4417, 64'h1c00_0048_53ff_ffff, 64'h1c00_004c_0280_0000,
        64'h1c00_0044_0280_4417, 64'h1c00_0048_53ff_ffff, 64'h1c00_004c_0280_0000,
        64'h1c00_0044_0280_4417, 64'h1c00_0048_53ff_ffff, 64'h1c00_004c_0280_0000,
        64'h1c00_0044_0280_4417, 64'h1c00_0048_53ff_ffff, 64'h1c00_004c_0280_0000
    };

    // long out_allowin stalls in cycles from time zero
    int stall_start [0:n_stall-1] = '{30, 70, 140};
    int stall_len   [0:n_stall-1] = '{20, 35, 12};

    logic [31:0] lfsr;
    int          errors     = 0;
    int          n_checked  = 0;
    int          n_buffered = 0;

    fetch_front #(
        .reset_pc (reset_pc)
    ) dut (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata),
        .out_valid         (out_valid),
        .out_pc            (out_pc),
        .out_inst          (out_inst),
        .out_allowin       (out_allowin)
    );

    inst_mem_model #(
        .reset_pc (reset_pc)
    ) u_mem (
        .clk     (clk),
        .reset   (reset),
        .req     (inst_sram_req),
        .addr    (inst_sram_addr),
        .addr_ok (inst_sram_addr_ok),
        .data_ok (inst_sram_data_ok),
        .rdata   (inst_sram_rdata)
    );

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic in_stall_phase(input int cyc);
        for (int i = 0; i < n_stall; i++) begin
            if (cyc >= stall_start[i] && cyc < stall_start[i] + stall_len[i]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic compare_word(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // back-pressure on the output port
    initial begin : allowin_driver
        int cyc;
        cyc         = 0;
        lfsr        = 32'hefa6_f498;
        out_allowin = 1'b0;
        forever begin
            @(posedge clk);
            cyc++;
            if (reset || in_stall_phase(cyc)) begin
                out_allowin <= 1'b0;
            end else begin
                out_allowin <= (rand_bits(2) != 32'd0);
            end
        end
    end

    // at most one request outstanding on the memory port
    initial begin : port_monitor
        logic pending;
        pending = 1'b0;
        forever begin
            @(posedge clk);
            if (!reset) begin
                if (inst_sram_data_ok && !dut.ds_allowin) begin
                    n_buffered++;   // return lands in the fetch buffer
                end
                if (inst_sram_req && pending && !inst_sram_data_ok) begin
                    errors++;
                    $display("ERROR at %0t ns: request raised before previous data_ok",
                             $time);
                end
                if (inst_sram_req && inst_sram_addr_ok) begin
                    pending = 1'b1;
                end else if (inst_sram_data_ok) begin
                    pending = 1'b0;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (n_exp * 40) @(posedge clk);
        $display("timeout: %0d of %0d output items arrived within %0d cycles",
                 n_checked, n_exp, n_exp * 40);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin : main_seq
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        // first cycle out of reset
        compare_word(32'(inst_sram_req), 32'd1, "inst_sram_req after reset");
        compare_word(inst_sram_addr, reset_pc, "first request address");
        compare_word(32'(out_valid), 32'd0, "out_valid after reset");
        compare_word(32'(dut.br_bus[br_tk_bit]), 32'd0, "branch taken after reset");
        for (int i = 0; i < n_exp; i++) begin
            while (!(out_valid && out_allowin)) @(posedge clk);
            compare_word(out_pc, exp_tab[i][63:32], $sformatf("pc of item %0d", i));
            compare_word(out_inst, exp_tab[i][31:0], $sformatf("inst of item %0d", i));
            n_checked++;
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        compare_word(32'(n_buffered != 0), 32'd1, "returns through the fetch buffer");
        $display("checked %0d items, %0d returns through the buffer, %0d errors",
                 n_checked, n_buffered, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: dv/inst_mem_model.sv
`timescale 1ns/1ns

module inst_mem_model #(
    parameter logic [fetch_pkg::addr_w-1:0] reset_pc = 32'h1c00_0000
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         req,
    input  logic [fetch_pkg::addr_w-1:0] addr,
    output logic                         addr_ok,
    output logic                         data_ok,
    output logic [fetch_pkg::inst_w-1:0] rdata
);
    import fetch_pkg::*;

    localparam int prog_len = 20;

    // word i sits at reset_pc + 4*i, B is {op_b, offs[15:0], offs[25:16]}
    logic [inst_w-1:0] prog [0:prog_len-1] = '{
        32'h0280_0401, 32'h0280_0802,
        32'h5000_2800,                  // 0x08: B +10 words to 0x30
        32'h0280_0c03, 32'h0280_1004,
        32'h0280_1405,                  // 0x14: entered from the backward B
        32'h5000_2800,                  // 0x18: B +10 words to 0x40, forward exit
        32'h5001_9000,                  // slot word that is itself a B, must be squashed
        32'h0280_2008, 32'h0280_2409, 32'h0280_2810, 32'h0280_2c11,
        32'h0280_3012, 32'h0280_3413,
        32'h53ff_dfff,                  // 0x38: B -9 words back to 0x14
        32'h0280_3c15, 32'h0280_4016, 32'h0280_4417,
        32'h53ff_ffff,                  // 0x48: B -1 word, tight loop on 0x44
        32'h0280_4c19
    };

    logic [31:0]       lfsr;
    logic              busy;        // one request in flight
    logic              grant;       // addr_ok enable for this cycle
    logic [1:0]        wait_cnt;    // cycles left before data_ok
    logic [inst_w-1:0] rdata_q;

    // galois lfsr, one step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic [inst_w-1:0] read_word(input logic [addr_w-1:0] a);
        logic [addr_w-1:0] offs;
        int                idx;
        offs = a - reset_pc;
        idx  = int'(offs[addr_w-1:2]);
        if (offs[1:0] == 2'b00 && idx < prog_len) begin
            return prog[idx];
        end
        return nop_inst;    // outside the program
    endfunction

    assign data_ok = busy && (wait_cnt == 2'd0);
    assign addr_ok = (!busy || data_ok) && grant;
    assign rdata   = rdata_q;

    always @(posedge clk) begin
        if (reset) begin
            lfsr     = 32'hefa6_f498;
            busy     <= 1'b0;
            grant    <= 1'b0;
            wait_cnt <= 2'd0;
            rdata_q  <= nop_inst;
        end else begin
            grant <= (rand_bits(2) != 32'd0);   // roughly 3 cycles in 4
            if (data_ok) begin
                busy <= 1'b0;
            end else if (busy) begin
                wait_cnt <= wait_cnt - 2'd1;
            end
            if (req && addr_ok) begin
                busy     <= 1'b1;
                wait_cnt <= 2'(rand_bits(2));   // data_ok 1 to 4 cycles on
                rdata_q  <= read_word(addr);
            end
        end
    end

endmodule

// File: verilog/fetch_front.sv
`timescale 1ns/1ns

module fetch_front #(
    parameter logic [fetch_pkg::addr_w-1:0] reset_pc = 32'h1c00_0000
) (
    input  logic                         clk,
    input  logic                         reset,
    // instruction memory, read only
    output logic                         inst_sram_req,
    output logic [fetch_pkg::addr_w-1:0] inst_sram_addr,
    input  logic                         inst_sram_addr_ok,
    input  logic                         inst_sram_data_ok,
    input  logic [fetch_pkg::inst_w-1:0] inst_sram_rdata,
    // decoded stream
    output logic                         out_valid,
    output logic [fetch_pkg::addr_w-1:0] out_pc,
    output logic [fetch_pkg::inst_w-1:0] out_inst,
    input  logic                         out_allowin
);
    import fetch_pkg::*;

    logic                  ds_allowin;
    logic [br_bus_w-1:0]   br_bus;       // redirect from decode
    logic                  fs_to_ds_valid;
    logic [fs_to_ds_w-1:0] fs_to_ds_bus;

    if_stage #(
        .reset_pc (reset_pc)
    ) u_if_stage (
        .clk               (clk),
        .reset             (reset),
        .ds_allowin        (ds_allowin),
        .br_bus            (br_bus),
        .fs_to_ds_valid    (fs_to_ds_valid),
        .fs_to_ds_bus      (fs_to_ds_bus),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata)
    );

    id_stage u_id_stage (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .ds_allowin     (ds_allowin),
        .br_bus         (br_bus),
        .out_valid      (out_valid),
        .out_pc         (out_pc),
        .out_inst       (out_inst),
        .out_allowin    (out_allowin)
    );

endmodule

// File: id_stage/id_stage.sv
`timescale 1ns/1ns

module id_stage (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             fs_to_ds_valid,
    input  logic [fetch_pkg::fs_to_ds_w-1:0] fs_to_ds_bus,
    output logic                             ds_allowin,
    output logic [fetch_pkg::br_bus_w-1:0]   br_bus,
    output logic                             out_valid,
    output logic [fetch_pkg::addr_w-1:0]     out_pc,
    output logic [fetch_pkg::inst_w-1:0]     out_inst,
    input  logic                             out_allowin
);
    import fetch_pkg::*;

    logic                  ds_valid;
    logic [fs_to_ds_w-1:0] ds_bus;
    logic [addr_w-1:0]     ds_pc;
    logic [inst_w-1:0]     ds_inst;
    logic                  ds_xfer;
    logic                  in_is_b;
    logic                  br_pend;
    logic [addr_w-1:0]     br_offs;
    logic [addr_w-1:0]     br_target;

    assign ds_allowin = !ds_valid || out_allowin;   // single stage, always ready to go
    assign ds_xfer    = fs_to_ds_valid && ds_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    // payload is only overwritten by the next accepted item
    always_ff @(posedge clk) begin
        if (ds_xfer) begin
            ds_bus <= fs_to_ds_bus;
        end
    end

    assign ds_inst = ds_bus[fs_to_ds_w-1:fs_inst_lsb];
    assign ds_pc   = ds_bus[fs_inst_lsb-1:0];

    // opcode check on the incoming word, so pending is set at the same edge
    assign in_is_b = fs_to_ds_bus[fs_to_ds_w-1 -: $bits(op_b)] == op_b;

    // held from B entering until the following word enters.
    // that word is the squashed slot, never a B, so this clears
    always_ff @(posedge clk) begin
        if (reset) begin
            br_pend <= 1'b0;
        end else if (ds_xfer) begin
            br_pend <= in_is_b;
        end
    end

    // offs26 = {inst[9:0], inst[25:10]}, word offset
    assign br_offs   = {{4{ds_inst[9]}}, ds_inst[9:0], ds_inst[25:10], 2'b00};
    assign br_target = ds_pc + br_offs;   // ds_bus still holds B after it leaves

    assign br_bus = {br_pend, br_target};

    assign out_valid = ds_valid;
    assign out_pc    = ds_pc;
    assign out_inst  = ds_inst;

    a_out_stable: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_allowin |=> out_valid && $stable(out_pc) && $stable(out_inst))
        else $error("output item changed while stalled");

endmodule

// File: if_stage/if_stage.sv
`timescale 1ns/1ns

module if_stage #(
    parameter logic [fetch_pkg::addr_w-1:0] reset_pc = 32'h1c00_0000
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             ds_allowin,
    input  logic [fetch_pkg::br_bus_w-1:0]   br_bus,
    output logic                             fs_to_ds_valid,
    output logic [fetch_pkg::fs_to_ds_w-1:0] fs_to_ds_bus,
    output logic                             inst_sram_req,
    output logic [fetch_pkg::addr_w-1:0]     inst_sram_addr,
    input  logic                             inst_sram_addr_ok,
    input  logic                             inst_sram_data_ok,
    input  logic [fetch_pkg::inst_w-1:0]     inst_sram_rdata
);
    import fetch_pkg::*;

    logic              fs_valid;       // request accepted, item not yet handed on
    logic              fs_ready_go;
    logic              fs_allowin;
    logic              req_accept;
    logic              fs_xfer;
    logic              br_taken;
    logic [addr_w-1:0] br_target;
    logic              redirect;
    logic [addr_w-1:0] fs_pc;
    logic [addr_w-1:0] seq_pc;
    logic [addr_w-1:0] nextpc;
    logic [inst_w-1:0] fs_inst;
    logic [inst_w-1:0] inst_buf;
    logic              inst_buf_valid;

    assign br_taken  = br_bus[br_tk_bit];
    assign br_target = br_bus[br_tk_bit-1:0];

    // while taken is high, whatever sits in fetch is the word after B.
    // the target is only requested once that word is in fetch, so an
    // empty fetch stage still asks for pc+4 first
    assign redirect = br_taken && fs_valid;

    // pre-IF
    assign seq_pc     = fs_pc + 32'd4;
    assign nextpc     = redirect ? br_target : seq_pc;
    assign req_accept = inst_sram_req && inst_sram_addr_ok;

    assign inst_sram_req  = fs_allowin;   // only ask when the result has a home
    assign inst_sram_addr = nextpc;

    // IF handshake
    assign fs_ready_go    = inst_sram_data_ok || inst_buf_valid;
    assign fs_allowin     = !fs_valid || (fs_ready_go && ds_allowin);
    assign fs_to_ds_valid = fs_valid && fs_ready_go;
    assign fs_xfer        = fs_to_ds_valid && ds_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
        end else if (fs_allowin) begin
            fs_valid <= req_accept;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_pc <= reset_pc - 32'd4;    // first nextpc comes out as reset_pc
        end else if (req_accept) begin
            fs_pc <= nextpc;
        end else if (redirect && fs_xfer) begin
            // slot left but the target request missed addr_ok,
            // park pc one word short so seq_pc lands on the target
            fs_pc <= br_target - 32'd4;
        end
    end

    // one-word hold for data that decode cannot take yet
    always_ff @(posedge clk) begin
        if (inst_sram_data_ok && !ds_allowin) begin
            inst_buf <= inst_sram_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            inst_buf_valid <= 1'b0;
        end else if (fs_xfer) begin
            inst_buf_valid <= 1'b0;
        end else if (inst_sram_data_ok && !ds_allowin) begin
            inst_buf_valid <= 1'b1;
        end
    end

    assign fs_inst = br_taken       ? nop_inst :
                     inst_buf_valid ? inst_buf :
                                      inst_sram_rdata;

    assign fs_to_ds_bus = {fs_inst, fs_pc};

    // memory side must only answer the single request in flight
    a_data_ok_outstanding: assert property (@(posedge clk) disable iff (reset)
        inst_sram_data_ok |-> fs_valid && !inst_buf_valid)
        else $error("data_ok without an outstanding request");

    // an offered item is not withdrawn before decode takes it
    a_fs_valid_hold: assert property (@(posedge clk) disable iff (reset)
        fs_to_ds_valid && !ds_allowin |=> fs_to_ds_valid)
        else $error("fs_to_ds_valid dropped while decode stalled");

endmodule

// File: common/fetch_pkg.sv
package fetch_pkg;

    // datapath widths
    localparam int addr_w = 32;
    localparam int inst_w = 32;

    // addi.w r0,r0,0, squashes the word after a taken branch
    localparam logic [inst_w-1:0] nop_inst = 32'h0280_0000;

    // major opcode of B, inst[31:26]
    localparam logic [5:0] op_b = 6'b010100;

    // branch bus is {taken, target}
    localparam int br_tk_bit = addr_w;            // taken sits above the target
    localparam int br_bus_w  = addr_w + 1;

    // fetch-to-decode bus is {inst, pc}
    localparam int fs_inst_lsb = addr_w;          // pc fills the low word
    localparam int fs_to_ds_w  = inst_w + addr_w;

endpackage
